//--- intr_settings.svh
// Interrupt CSR settings
// Data width, CSR addresses, write masks and feature switches
`ifndef INTR_SETTINGS_SVH
`define INTR_SETTINGS_SVH

// Data width of the core
`define XLEN 32

// CSR addresses
`define ADR_MIE      12'h304
`define ADR_MIP      12'h344
`define ADR_SIE      12'h104
`define ADR_SIP      12'h144
`define ADR_MIDELEG  12'h303
`define ADR_MENVCFG  12'h30A

// Write masks over the 12 interrupt bits
// Only SEIP and SSIP stored in mip, STIP comes from the timer compare
`define MIP_WMASK      12'h202
`define MIE_WMASK      12'hAAA
`define MIDELEG_WMASK  12'h222
`define SIE_WMASK      12'h222
`define MACHINE_BITS   12'h888

// Feature switches
`define S_SUPPORTED     1
`define SSTC_SUPPORTED  1

`endif

//--- intrCsrPkg.sv
// Interrupt CSR types
// Privilege and operation encodings, request and result structs
`include "intr_settings.svh"

package intrCsrPkg;

  // Current privilege of the hart
  typedef enum logic [1:0] {
    privUser    = 2'b00,
    privSuper   = 2'b01,
    privMachine = 2'b11
  } privMode;

  // CSR operation, none means idle
  typedef enum logic [1:0] {
    opNone  = 2'b00,
    opWrite = 2'b01,
    opSet   = 2'b10,
    opClear = 2'b11
  } csrOp;

  // Request from the execute stage
  typedef struct packed {
    csrOp              op;
    logic [11:0]       adr;
    logic [`XLEN-1:0]  wdata;
  } csrReq;

  // Raw interrupt sources
  typedef struct packed {
    logic mExt;
    logic sExt;
    logic mTimer;
    logic sTimer;
    logic mSw;
  } intrLines;

  // Interrupt to take; cause is the interrupt number
  typedef struct packed {
    logic        valid;
    logic        toSuper;
    logic [3:0]  cause;
  } trapReq;

  // Write strobes plus the value to store
  typedef struct packed {
    logic              mWriteMie;
    logic              mWriteMip;
    logic              sWriteSie;
    logic              sWriteSip;
    logic              writeDeleg;
    logic              writeEnv;
    logic [`XLEN-1:0]  wval;
  } csrWrite;

endpackage

//--- csrAccessCtrl.sv
// CSR access control for the interrupt registers
// Decodes the request, checks privilege, builds the write value,
// raises one write strobe and muxes the read data
`timescale 1ns/100ps
`include "intr_settings.svh"

module csrAccessCtrl (
  input  logic                 clk,
  input  logic                 reset,
  input  intrCsrPkg::csrReq    req,
  input  intrCsrPkg::privMode  priv,
  input  logic [11:0]          mie,
  input  logic [11:0]          mip,
  input  logic [11:0]          mideleg,
  input  logic                 stce,
  output logic [`XLEN-1:0]     rdata,
  output logic                 illegal,
  output intrCsrPkg::csrWrite  wr
);
  import intrCsrPkg::*;

  logic [`XLEN-1:0]  oldVal;
  logic [`XLEN-1:0]  newVal;
  logic              known;
  logic              privLow;
  logic              active;
  logic              doWrite;

  ////////////////////////////////////////
  // Decode and read mux
  ////////////////////////////////////////

  // Supervisor views are the machine registers masked by delegation
  always_comb begin
    oldVal = '0;
    known  = 1'b1;
    case (req.adr)
      `ADR_MIE:     oldVal = {{(`XLEN-12){1'b0}}, mie};
      `ADR_MIP:     oldVal = {{(`XLEN-12){1'b0}}, mip};
      `ADR_SIE:     oldVal = {{(`XLEN-12){1'b0}}, mie & mideleg};
      `ADR_SIP:     oldVal = {{(`XLEN-12){1'b0}}, mip & mideleg};
      `ADR_MIDELEG: oldVal = {{(`XLEN-12){1'b0}}, mideleg};
      // STCE sits in the top bit of menvcfg
      `ADR_MENVCFG: oldVal = {stce, {(`XLEN-1){1'b0}}};
      default:      known  = 1'b0;
    endcase
  end

  // Address bits 9:8 give the lowest privilege allowed
  assign privLow = req.adr[9:8] > priv;
  assign active  = req.op != opNone;
  assign illegal = active & (~known | privLow);

  // Illegal accesses read as zero
  assign rdata = illegal ? '0 : oldVal;

  ////////////////////////////////////////
  // Write value and strobes
  ////////////////////////////////////////

  // Set and clear work on the value as seen at this address
  always_comb begin
    case (req.op)
      opSet:   newVal = oldVal | req.wdata;
      opClear: newVal = oldVal & ~req.wdata;
      default: newVal = req.wdata;
    endcase
  end

  // No CSR writes accepted while the core is held in reset
  assign doWrite = active & ~illegal & ~reset;

  always_comb begin
    wr      = '0;
    wr.wval = newVal;
    if (doWrite) begin
      case (req.adr)
        `ADR_MIE:     wr.mWriteMie  = 1'b1;
        `ADR_MIP:     wr.mWriteMip  = 1'b1;
        `ADR_SIE:     wr.sWriteSie  = 1'b1;
        `ADR_SIP:     wr.sWriteSip  = 1'b1;
        `ADR_MIDELEG: wr.writeDeleg = 1'b1;
        `ADR_MENVCFG: wr.writeEnv   = 1'b1;
        default:      ;
      endcase
    end
  end

endmodule

//--- intrEnablePending.sv
// Interrupt enable and pending registers (mie, mip)
// Stores the writable pending bits and the enables under fixed masks,
// and merges in the hard-wired interrupt lines
`timescale 1ns/100ps
`include "intr_settings.svh"

module intrEnablePending (
  input  logic                 clk,
  input  logic                 reset,
  input  intrCsrPkg::csrWrite  wr,
  input  logic [11:0]          mideleg,
  input  logic                 stce,
  input  intrCsrPkg::intrLines lines,
  output logic [11:0]          mie,
  output logic [11:0]          mip
);

  logic [11:0]  mipStored;
  logic [11:0]  sipWMask;
  logic [11:0]  sieWMask;
  logic         stip;

  ////////////////////////////////////////
  // Write masks
  ////////////////////////////////////////

  // Only SSIP is writable through sip, and only when delegated
  assign sipWMask = 12'h002 & mideleg;
  // sie reaches the supervisor enables that are delegated
  assign sieWMask = `SIE_WMASK & mideleg;

  ////////////////////////////////////////
  // Stored pending bits
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mipStored <= '0;
    end else if (wr.mWriteMip) begin
      mipStored <= wr.wval[11:0] & `MIP_WMASK;
    end else if (wr.sWriteSip) begin
      // Bits outside the sip view keep their value
      mipStored <= (wr.wval[11:0] & sipWMask) | (mipStored & ~sipWMask);
    end
  end

  ////////////////////////////////////////
  // Enables
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      mie <= '0;
    end else if (wr.mWriteMie) begin
      mie <= wr.wval[11:0] & `MIE_WMASK;
    end else if (wr.sWriteSie) begin
      // Machine bits and undelegated supervisor bits stay put
      mie <= (wr.wval[11:0] & sieWMask) |
             (mie & (`MACHINE_BITS | (`SIE_WMASK & ~mideleg)));
    end
  end

  // STIP follows the timer compare when STCE is on
  assign stip = ((`SSTC_SUPPORTED != 0) && stce) ? lines.sTimer : mipStored[5];

  // Pending view, even bits are hard zero
  assign mip = {lines.mExt,   1'b0, lines.sExt | mipStored[9], 1'b0,
                lines.mTimer, 1'b0, stip,                      1'b0,
                lines.mSw,    1'b0, mipStored[1],              1'b0};

endmodule

//--- intrDelegEnv.sv
// Interrupt delegation and timer-compare enable
// Holds mideleg and the STCE bit of menvcfg
`timescale 1ns/100ps
`include "intr_settings.svh"

module intrDelegEnv (
  input  logic                 clk,
  input  logic                 reset,
  input  intrCsrPkg::csrWrite  wr,
  output logic [11:0]          mideleg,
  output logic                 stce
);

  logic [11:0]  delegMask;

  // Only supervisor interrupts can be delegated
  assign delegMask = (`S_SUPPORTED != 0) ? `MIDELEG_WMASK : 12'h000;

  // Delegation register
  always_ff @(posedge clk) begin
    if (reset) begin
      mideleg <= '0;
    end else if (wr.writeDeleg) begin
      mideleg <= wr.wval[11:0] & delegMask;
    end
  end

  // STCE is the top bit of menvcfg
  always_ff @(posedge clk) begin
    if (reset) begin
      stce <= 1'b0;
    end else if (wr.writeEnv) begin
      stce <= wr.wval[`XLEN-1];
    end
  end

endmodule

//--- intrSelect.sv
// Interrupt selection
// Routes ready interrupts by delegation and privilege and picks
// one by the fixed priority order
`timescale 1ns/100ps

module intrSelect (
  input  logic [11:0]          mie,
  input  logic [11:0]          mip,
  input  logic [11:0]          mideleg,
  input  intrCsrPkg::privMode  priv,
  input  logic                 mstatusMie,
  input  logic                 mstatusSie,
  output intrCsrPkg::trapReq   trap
);
  import intrCsrPkg::*;

  logic [11:0]  ready;
  logic [11:0]  taken;
  logic         mEnable;
  logic         sEnable;

  // Pending and enabled
  assign ready = mip & mie;

  // Machine interrupts always taken below machine mode
  assign mEnable = (priv != privMachine) | mstatusMie;
  // Delegated ones never reach machine mode
  assign sEnable = (priv == privUser) | ((priv == privSuper) & mstatusSie);

  assign taken = ready & ((~mideleg & {12{mEnable}}) |
                          (mideleg & {12{sEnable}}));

  ////////////////////////////////////////
  // Priority pick
  ////////////////////////////////////////

  // Order: MEI, MSI, MTI, SEI, SSI, STI
  always_comb begin
    trap       = '0;
    trap.valid = |taken;
    if (taken[11]) begin
      trap.cause = 4'd11;
    end else if (taken[3]) begin
      trap.cause = 4'd3;
    end else if (taken[7]) begin
      trap.cause = 4'd7;
    end else if (taken[9]) begin
      trap.cause = 4'd9;
    end else if (taken[1]) begin
      trap.cause = 4'd1;
    end else begin
      // Also the idle value, so cause stays a legal number
      trap.cause = 4'd5;
    end
    trap.toSuper = trap.valid & mideleg[trap.cause];
  end

endmodule

//--- intrCsrTop.sv
// Interrupt CSR block top level
// Access control in front of the enable/pending and delegation
// registers, with the interrupt selector behind them
`timescale 1ns/100ps
`include "intr_settings.svh"

module intrCsrTop (
  input  logic                 clk,
  input  logic                 reset,
  input  intrCsrPkg::csrReq    req,
  input  intrCsrPkg::privMode  priv,
  input  intrCsrPkg::intrLines lines,
  input  logic                 mstatusMie,
  input  logic                 mstatusSie,
  output logic [`XLEN-1:0]     rdata,
  output logic                 illegal,
  output intrCsrPkg::trapReq   trap
);
  import intrCsrPkg::*;

  csrWrite      wr;
  logic [11:0]  mie;
  logic [11:0]  mip;
  logic [11:0]  mideleg;
  logic         stce;

  // Request decode and read data
  csrAccessCtrl accessCtrl (.clk(clk), .reset(reset), .req(req), .priv(priv),
    .mie(mie), .mip(mip), .mideleg(mideleg), .stce(stce),
    .rdata(rdata), .illegal(illegal), .wr(wr));

  // mie and mip storage
  intrEnablePending enablePending (.clk(clk), .reset(reset), .wr(wr),
    .mideleg(mideleg), .stce(stce), .lines(lines), .mie(mie), .mip(mip));

  // mideleg and STCE
  intrDelegEnv delegEnv (.clk(clk), .reset(reset), .wr(wr),
    .mideleg(mideleg), .stce(stce));

  // Interrupt routing and priority
  intrSelect select (.mie(mie), .mip(mip), .mideleg(mideleg), .priv(priv),
    .mstatusMie(mstatusMie), .mstatusSie(mstatusSie), .trap(trap));

endmodule

//--- intrCsr_checker.sv
// Interrupt CSR assertions
// Protocol and result checks on the top level, attached by bind
`timescale 1ns/100ps
`include "intr_settings.svh"

module intrCsrChecker (
  input  logic                 clk,
  input  logic                 reset,
  input  intrCsrPkg::csrReq    req,
  input  logic                 illegal,
  input  intrCsrPkg::trapReq   trap,
  input  intrCsrPkg::csrWrite  wr
);
  import intrCsrPkg::*;

  logic  anyStrobe;
  logic  causeOk;

  assign anyStrobe = wr.mWriteMie | wr.mWriteMip | wr.sWriteSie |
                     wr.sWriteSip | wr.writeDeleg | wr.writeEnv;
  // Interrupt numbers this block can report
  assign causeOk = trap.cause inside {4'd1, 4'd3, 4'd5, 4'd7, 4'd9, 4'd11};

  idleNotIllegal: assert property (@(posedge clk) (req.op == opNone) |-> !illegal)
    else $error("illegal raised on an idle request");

  noWriteWhenIllegal: assert property (@(posedge clk) illegal |-> !anyStrobe)
    else $error("write strobe fired on an illegal access");

  causeInRange: assert property (@(posedge clk) causeOk)
    else $error("trap cause outside the six interrupt numbers");

  // Registers are clear right after reset
  quietAfterReset: assert property (@(posedge clk) reset |=> !trap.valid)
    else $error("trap valid in the cycle after reset");

endmodule

bind intrCsrTop intrCsrChecker assertions (.clk(clk), .reset(reset), .req(req),
  .illegal(illegal), .trap(trap), .wr(wr));

//--- intrCsrTb.sv
// Interrupt CSR testbench
// Directed tests of reads, writes, privilege checks and trap selection
// against a small register model, plus LFSR-random trap checks
`timescale 1ns/100ps
`include "intr_settings.svh"

module intrCsrTb;
  import intrCsrPkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 10;
  localparam int DIRECTED_CYCLES = 90;
  localparam int RANDOM_ITERS    = 180;
  // Random round is four writes and one trap check, then doubled for margin
  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_ITERS * 5);

  logic              clk = 1'b0;
  logic              reset;
  csrReq             req;
  privMode           priv;
  intrLines          lines;
  logic              mstatusMie;
  logic              mstatusSie;
  logic [`XLEN-1:0]  rdata;
  logic              illegal;
  trapReq            trap;

  // Register model
  logic [11:0]  mdlMie;
  logic [11:0]  mdlStored;
  logic [11:0]  mdlDeleg;
  logic         mdlStce;
  logic [31:0]  lfsrState;
  int           errorCount = 0;

  intrCsrTop uut (.clk(clk), .reset(reset), .req(req), .priv(priv), .lines(lines),
    .mstatusMie(mstatusMie), .mstatusSie(mstatusSie), .rdata(rdata),
    .illegal(illegal), .trap(trap));

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // Random source and model
  ////////////////////////////////////////

  // Galois LFSR, one step per bit
  function automatic logic nextBit();
    logic b;
    b = lfsrState[0];
    lfsrState = (lfsrState >> 1) ^ (b ? 32'h80200003 : 32'h0);
    return b;
  endfunction

  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < count; i++) begin
      v = {v[30:0], nextBit()};
    end
    return v;
  endfunction

  // Pending view: lines for the hard-wired bits, storage for SEIP and SSIP
  function automatic logic [11:0] modelMip();
    logic [11:0] m;
    m = 12'h000;
    m[11] = lines.mExt;
    m[9]  = lines.sExt | mdlStored[9];
    m[7]  = lines.mTimer;
    m[5]  = mdlStce ? lines.sTimer : mdlStored[5];
    m[3]  = lines.mSw;
    m[1]  = mdlStored[1];
    return m;
  endfunction

  function automatic logic knownAdr(input logic [11:0] adr);
    return adr inside {`ADR_MIE, `ADR_MIP, `ADR_SIE, `ADR_SIP, `ADR_MIDELEG, `ADR_MENVCFG};
  endfunction

  function automatic logic [`XLEN-1:0] modelView(input logic [11:0] adr);
    logic [11:0] v;
    v = 12'h000;
    case (adr)
      `ADR_MIE:     v = mdlMie;
      `ADR_MIP:     v = modelMip();
      `ADR_SIE:     v = mdlMie & mdlDeleg;
      `ADR_SIP:     v = modelMip() & mdlDeleg;
      `ADR_MIDELEG: v = mdlDeleg;
      `ADR_MENVCFG: return {mdlStce, {(`XLEN-1){1'b0}}};
      default:      v = 12'h000;
    endcase
    return {{(`XLEN-12){1'b0}}, v};
  endfunction

  // First taken bit in order 11, 3, 7, 9, 1, 5
  function automatic trapReq modelTrap();
    trapReq       t;
    logic [11:0]  ready;
    logic [23:0]  order;
    logic [3:0]   num;
    logic         machOk;
    logic         superOk;
    order   = {4'd11, 4'd3, 4'd7, 4'd9, 4'd1, 4'd5};
    ready   = modelMip() & mdlMie;
    machOk  = (priv != privMachine) || mstatusMie;
    superOk = (priv == privUser) || ((priv == privSuper) && mstatusSie);
    t = '0;
    for (int i = 0; i < 6; i++) begin
      num = order[23 - 4 * i -: 4];
      if (!t.valid && ready[num] && (mdlDeleg[num] ? superOk : machOk)) begin
        t.valid   = 1'b1;
        t.toSuper = mdlDeleg[num];
        t.cause   = num;
      end
    end
    return t;
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic reportFailure(input string what);
    errorCount++;
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "Run stopped");
  endtask

  task automatic checkData(input string name, input logic [`XLEN-1:0] exp,
      input logic [`XLEN-1:0] act);
    if (act !== exp) begin
      reportFailure($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      reportFailure($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic checkTrap(input string name, input trapReq exp, input trapReq act);
    logic same;
    // Cause means nothing while no trap is valid
    if (exp.valid) begin
      same = (act === exp);
    end else begin
      same = (act.valid === 1'b0) && (act.toSuper === 1'b0);
    end
    if (!same) begin
      reportFailure($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  ////////////////////////////////////////
  // Bus access
  ////////////////////////////////////////

  // Back to the drive point just after the next rising edge
  task automatic stepCycle();
    @(posedge clk);
    #1;
  endtask

  // One request, checked mid-cycle; the model follows at the edge
  task automatic csrAccess(input string name, input csrOp op, input logic [11:0] adr,
      input logic [`XLEN-1:0] wdata, input privMode p,
      output logic [`XLEN-1:0] val, output logic ill);
    logic              expIll;
    logic [`XLEN-1:0]  oldVal;
    logic [`XLEN-1:0]  newVal;
    logic [11:0]       wMask;
    logic [11:0]       nextMie;
    logic [11:0]       nextStored;
    logic [11:0]       nextDeleg;
    logic              nextStce;
    req.op    = op;
    req.adr   = adr;
    req.wdata = wdata;
    priv      = p;
    #2;
    expIll = (op != opNone) && (!knownAdr(adr) || (adr[9:8] > p));
    oldVal = expIll ? '0 : modelView(adr);
    checkFlag(name, expIll, illegal);
    if (op != opNone) begin
      checkData(name, oldVal, rdata);
    end
    checkTrap(name, modelTrap(), trap);
    val = rdata;
    ill = illegal;
    case (op)
      opSet:   newVal = oldVal | wdata;
      opClear: newVal = oldVal & ~wdata;
      default: newVal = wdata;
    endcase
    nextMie    = mdlMie;
    nextStored = mdlStored;
    nextDeleg  = mdlDeleg;
    nextStce   = mdlStce;
    if ((op != opNone) && !expIll) begin
      case (adr)
        `ADR_MIE:     nextMie = newVal[11:0] & `MIE_WMASK;
        `ADR_MIP:     nextStored = newVal[11:0] & `MIP_WMASK;
        `ADR_SIE: begin
          wMask   = `SIE_WMASK & mdlDeleg;
          nextMie = (newVal[11:0] & wMask) | (mdlMie & ~wMask);
        end
        `ADR_SIP: begin
          // SSIP is the only pending bit sip reaches
          wMask      = 12'h002 & mdlDeleg;
          nextStored = (newVal[11:0] & wMask) | (mdlStored & ~wMask);
        end
        `ADR_MIDELEG: nextDeleg = newVal[11:0] & `MIDELEG_WMASK;
        `ADR_MENVCFG: nextStce = newVal[`XLEN-1];
        default:      nextStce = mdlStce;
      endcase
    end
    stepCycle();
    mdlMie    = nextMie;
    mdlStored = nextStored;
    mdlDeleg  = nextDeleg;
    mdlStce   = nextStce;
    req.op    = opNone;
    req.wdata = '0;
  endtask

  task automatic readCsr(input string name, input logic [11:0] adr,
      output logic [`XLEN-1:0] val);
    logic ill;
    csrAccess(name, opSet, adr, '0, privMachine, val, ill);
  endtask

  task automatic writeCsr(input string name, input logic [11:0] adr,
      input logic [`XLEN-1:0] data);
    logic [`XLEN-1:0] val;
    logic ill;
    csrAccess(name, opWrite, adr, data, privMachine, val, ill);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic resetValues();
    logic [`XLEN-1:0] v;
    checkFlag("reset trap valid", 1'b0, trap.valid);
    readCsr("reset mie", `ADR_MIE, v);
    checkData("reset mie", '0, v);
    readCsr("reset mip", `ADR_MIP, v);
    checkData("reset mip", '0, v);
    readCsr("reset sie", `ADR_SIE, v);
    checkData("reset sie", '0, v);
    readCsr("reset sip", `ADR_SIP, v);
    checkData("reset sip", '0, v);
    readCsr("reset mideleg", `ADR_MIDELEG, v);
    checkData("reset mideleg", '0, v);
  endtask

  task automatic machineWrites();
    logic [`XLEN-1:0] v;
    writeCsr("mie all ones", `ADR_MIE, '1);
    readCsr("mie all ones", `ADR_MIE, v);
    checkData("mie all ones", 32'h0000_0AAA, v);
    writeCsr("mip all ones", `ADR_MIP, '1);
    readCsr("mip all ones", `ADR_MIP, v);
    checkData("mip all ones", 32'h0000_0202, v);
    writeCsr("mip clear", `ADR_MIP, '0);
    // External line shows up with no write
    lines.mExt = 1'b1;
    readCsr("mip external line", `ADR_MIP, v);
    checkData("mip external line", 32'h0000_0800, v);
    lines.mExt = 1'b0;
    writeCsr("mie clear", `ADR_MIE, '0);
  endtask

  task automatic supervisorViews();
    logic [`XLEN-1:0] v;
    logic [`XLEN-1:0] mipVal;
    writeCsr("mideleg all ones", `ADR_MIDELEG, '1);
    readCsr("mideleg all ones", `ADR_MIDELEG, v);
    checkData("mideleg all ones", 32'h0000_0222, v);
    writeCsr("mie setup", `ADR_MIE, 32'h0000_0AAA);
    writeCsr("sie zero", `ADR_SIE, '0);
    readCsr("mie after sie zero", `ADR_MIE, v);
    checkData("mie after sie zero", 32'h0000_0888, v);
    writeCsr("sie ones", `ADR_SIE, '1);
    readCsr("sie ones", `ADR_SIE, v);
    checkData("sie ones", 32'h0000_0222, v);
    writeCsr("mip clear", `ADR_MIP, '0);
    writeCsr("sip ones", `ADR_SIP, '1);
    readCsr("mip after sip ones", `ADR_MIP, v);
    checkData("mip after sip ones", 32'h0000_0002, v);
    // sip is mip seen through mideleg
    lines.sExt = 1'b1;
    readCsr("mip with external", `ADR_MIP, mipVal);
    readCsr("sip with external", `ADR_SIP, v);
    checkData("sip masked view", mipVal & 32'h0000_0222, v);
    lines.sExt = 1'b0;
    // Nothing delegated, supervisor writes are lost
    writeCsr("mideleg zero", `ADR_MIDELEG, '0);
    readCsr("mip before sip", `ADR_MIP, mipVal);
    writeCsr("sie zero undelegated", `ADR_SIE, '0);
    writeCsr("sip zero undelegated", `ADR_SIP, '0);
    readCsr("mie undelegated", `ADR_MIE, v);
    checkData("mie undelegated", 32'h0000_0AAA, v);
    readCsr("mip undelegated", `ADR_MIP, v);
    checkData("mip undelegated", mipVal, v);
    writeCsr("mip cleanup", `ADR_MIP, '0);
  endtask

  task automatic setAndClear();
    logic [`XLEN-1:0] v;
    logic [`XLEN-1:0] rnd;
    logic ill;
    csrOp op;
    writeCsr("mie zero", `ADR_MIE, '0);
    csrAccess("mie set", opSet, `ADR_MIE, 32'h0000_000A, privMachine, v, ill);
    csrAccess("mie set high", opSet, `ADR_MIE, 32'h0000_0880, privMachine, v, ill);
    csrAccess("mie clear", opClear, `ADR_MIE, 32'h0000_0008, privMachine, v, ill);
    readCsr("mie after set and clear", `ADR_MIE, v);
    checkData("mie after set and clear", 32'h0000_0882, v);
    csrAccess("mie from supervisor", opWrite, `ADR_MIE, '1, privSuper, v, ill);
    checkFlag("mie from supervisor", 1'b1, ill);
    checkData("mie from supervisor", '0, v);
    csrAccess("sie from user", opWrite, `ADR_SIE, '1, privUser, v, ill);
    checkFlag("sie from user", 1'b1, ill);
    csrAccess("unknown address", opWrite, 12'h305, '1, privMachine, v, ill);
    checkFlag("unknown address", 1'b1, ill);
    checkData("unknown address", '0, v);
    csrAccess("idle request", opNone, 12'h305, '1, privUser, v, ill);
    checkFlag("idle request", 1'b0, ill);
    readCsr("mie after illegal", `ADR_MIE, v);
    checkData("mie after illegal", 32'h0000_0882, v);
    for (int i = 0; i < 8; i++) begin
      rnd = randomBits(12);
      op = nextBit() ? opSet : opClear;
      csrAccess("random set/clear mie", op, `ADR_MIE, rnd, privMachine, v, ill);
    end
    readCsr("mie after random set/clear", `ADR_MIE, v);
  endtask

  task automatic timerCompare();
    logic [`XLEN-1:0] v;
    writeCsr("stce on", `ADR_MENVCFG, 32'h8000_0000);
    readCsr("menvcfg", `ADR_MENVCFG, v);
    checkData("menvcfg", 32'h8000_0000, v);
    lines.sTimer = 1'b1;
    readCsr("stip follows line", `ADR_MIP, v);
    checkFlag("stip follows line", 1'b1, v[5]);
    lines.sTimer = 1'b0;
    readCsr("stip drops with line", `ADR_MIP, v);
    checkFlag("stip drops with line", 1'b0, v[5]);
    writeCsr("stce off", `ADR_MENVCFG, '0);
    lines.sTimer = 1'b1;
    writeCsr("mip stip write", `ADR_MIP, 32'h0000_0020);
    readCsr("stip from storage", `ADR_MIP, v);
    checkFlag("stip from storage", 1'b0, v[5]);
    lines.sTimer = 1'b0;
  endtask

  ////////////////////////////////////////
  // Random trap selection
  ////////////////////////////////////////

  task automatic randomTraps();
    logic [31:0] rnd;
    for (int i = 0; i < RANDOM_ITERS; i++) begin
      writeCsr("random mideleg", `ADR_MIDELEG, randomBits(12));
      writeCsr("random mie", `ADR_MIE, randomBits(32));
      writeCsr("random mip", `ADR_MIP, randomBits(32));
      rnd = randomBits(1);
      writeCsr("random menvcfg", `ADR_MENVCFG, {rnd[0], {(`XLEN-1){1'b0}}});
      rnd = randomBits(5);
      lines = rnd[4:0];
      rnd = randomBits(2);
      case (rnd[1:0])
        2'd0:    priv = privUser;
        2'd1:    priv = privSuper;
        default: priv = privMachine;
      endcase
      mstatusMie = nextBit();
      mstatusSie = nextBit();
      #2;
      checkTrap("random trap", modelTrap(), trap);
      stepCycle();
    end
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    reset      = 1'b1;
    req        = '0;
    priv       = privMachine;
    lines      = '0;
    mstatusMie = 1'b0;
    mstatusSie = 1'b0;
    lfsrState  = 32'hdbcea623;
    mdlMie     = '0;
    mdlStored  = '0;
    mdlDeleg   = '0;
    mdlStce    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
    resetValues();
    machineWrites();
    supervisorViews();
    setAndClear();
    timerCompare();
    randomTraps();
    if (errorCount == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      reportFailure("Checks failed during the run");
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    reportFailure("Timeout: the tests did not finish in time");
  end

endmodule

//--- sim.f
+incdir+.
intrCsrPkg.sv
csrAccessCtrl.sv
intrEnablePending.sv
intrDelegEnv.sv
intrSelect.sv
intrCsrTop.sv
intrCsr_checker.sv
intrCsrTb.sv

//--- run.sh
#!/bin/sh
# Build the interrupt CSR simulation with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps -f sim.f \
  --top-module intrCsrTb -o intrCsrSim \
  && ./obj_dir/intrCsrSim \
  || exit 1
